/* Makefile */
# Verilator flow for the emu_uncore testbench.

VERILATOR ?= verilator
TOP       ?= tb_emu_uncore
FILELIST  ?= emu_uncore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* emu_uncore.f */
+incdir+verilog
verilog/emu_pkg.sv
verilog/mem_axi_bridge.sv
verilog/axi_ram.sv
verilog/console_fifo.sv
verilog/console_drain.sv
verilog/emu_uncore.sv
verif/emu_uncore_properties.sv
verif/tb_emu_uncore.sv

/* verif/emu_uncore_properties.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module emu_uncore_properties (
    input logic clk,
    input logic resetn,
    input logic mem_valid,
    input logic mem_ready,
    input logic char_valid
);
    localparam int GAP = `EMU_CONSOLE_GAP;

    int unsigned fail_count;

    initial fail_count = 0;

    ////////////////////////////////////////
    // native port
    ////////////////////////////////////////

    ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        mem_ready |-> mem_valid)
    else begin
        fail_count++;
        $error("mem_ready high without mem_valid");
    end

    ////////////////////////////////////////
    // console pacing
    ////////////////////////////////////////

    char_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
        char_valid |=> !char_valid)
    else begin
        fail_count++;
        $error("char_valid high in two consecutive cycles");
    end

    // strobes closer than the gap.
    for (genvar i = 2; i < GAP; i++) begin : gen_gap
        char_spacing: assert property (@(posedge clk) disable iff (!resetn)
            char_valid |-> !$past(char_valid, i))
        else begin
            fail_count++;
            $error("char_valid repeated %0d cycles after the previous one", i);
        end
    end

    quiet_in_reset: assert property (@(posedge clk)
        !resetn && $past(!resetn) |-> !mem_ready && !char_valid)
    else begin
        fail_count++;
        $error("mem_ready or char_valid high during reset");
    end

endmodule

bind emu_uncore emu_uncore_properties props0 (
    .clk        (clk),
    .resetn     (resetn),
    .mem_valid  (mem_valid),
    .mem_ready  (mem_ready),
    .char_valid (char_valid)
);

/* verif/tb_emu_uncore.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module tb_emu_uncore;
    import emu_pkg::*;

    localparam int IDX_W         = $clog2(`EMU_RAM_WORDS);
    localparam int REQ_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 40 * `EMU_CONSOLE_DEPTH * `EMU_CONSOLE_GAP;
    localparam int N_WORDS       = 24;

    logic        clk;
    logic        resetn;
    logic        mem_valid;
    mem_req_t    mem_req;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    logic        char_valid;
    logic [7:0]  char_data;

    logic [31:0] ref_mem [`EMU_RAM_WORDS];
    logic [7:0]  char_q [$];            // console bytes still to come.
    logic [31:0] addr_list [N_WORDS];
    int          err_count;
    int          timeout_count;
    int          check_count;

    emu_uncore dut0 (
        .clk        (clk),
        .resetn     (resetn),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .char_valid (char_valid),
        .char_data  (char_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // expected mem_rdata, ram image updated on writes.
    function automatic logic [31:0] ref_access(input mem_req_t req);
        logic [IDX_W-1:0] idx;
        logic [31:0]      result;
        idx    = req.addr[IDX_W+1:2];     // wraps mod ram size.
        result = 32'h0;
        if (req.addr[31:28] == 4'h0) begin
            if (|req.wstrb) begin
                for (int i = 0; i < 4; i++) begin
                    if (req.wstrb[i]) ref_mem[idx][8*i +: 8] = req.wdata[8*i +: 8];
                end
            end else begin
                result = ref_mem[idx];
            end
        end
        return result;
    endfunction

    function automatic mem_req_t make_req(input logic [31:0] addr, input logic [31:0] wdata,
                                          input logic [3:0] wstrb);
        mem_req_t r;
        r.addr  = addr;
        r.wdata = wdata;
        r.wstrb = wstrb;
        r.instr = 1'b0;
        return r;
    endfunction

    ////////////////////////////////////////
    // run control
    ////////////////////////////////////////

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 check_count, err_count, timeout_count, dut0.props0.fail_count);
        if (err_count == 0 && timeout_count == 0 && dut0.props0.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic issue(input mem_req_t req);
        logic [31:0] expected;
        int          cycles;
        expected = ref_access(req);
        cycles   = 0;
        @(posedge clk);
        mem_valid <= 1'b1;
        mem_req   <= req;
        @(negedge clk);
        while (!mem_ready && cycles < REQ_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!mem_ready) begin
            $display("timeout: request to address %h never got mem_ready", req.addr);
            timeout_count++;
        end else begin
            check_count++;
            if (mem_rdata !== expected) begin
                $display("error mem_rdata addr %h: got %h, expected %h",
                         req.addr, mem_rdata, expected);
                err_count++;
            end
        end
    endtask

    task automatic idle();
        @(posedge clk);
        mem_valid <= 1'b0;
    endtask

    task automatic console_write(input logic [7:0] b, input logic [3:0] strb);
        char_q.push_back(strb[0] ? b : 8'h00);
        issue(make_req(`EMU_CONSOLE_ADDR, {24'($urandom), b}, strb));
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (char_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (char_q.size() != 0) begin
            $display("timeout: %0d console bytes never reached char_data", char_q.size());
            timeout_count++;
        end
    endtask

    ////////////////////////////////////////
    // console compare
    ////////////////////////////////////////

    always @(negedge clk) begin
        logic [7:0] exp_char;
        if (resetn === 1'b1 && char_valid === 1'b1) begin
            if (char_q.size() == 0) begin
                $display("char_valid with no console byte expected, char_data %h", char_data);
                err_count++;
            end else begin
                exp_char = char_q.pop_front();
                check_count++;
                if (char_data !== exp_char) begin
                    $display("error char_data: got %h, expected %h", char_data, exp_char);
                    err_count++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        logic [3:0] strb;
        void'($urandom(32'h46c5eb89));
        err_count     = 0;
        timeout_count = 0;
        check_count   = 0;
        resetn    <= 1'b0;
        mem_valid <= 1'b0;
        mem_req   <= '0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;

        // quiet outputs with no requests.
        repeat (16) begin
            @(negedge clk);
            check_count++;
            if (mem_ready !== 1'b0 || char_valid !== 1'b0) begin
                $display("error idle mem_ready %h, char_valid %h", mem_ready, char_valid);
                err_count++;
            end
        end

        // full words, read back through aliases above 4 KiB.
        for (int i = 0; i < N_WORDS; i++) begin
            addr_list[i] = {4'h0, 28'($urandom)} & 32'hffff_fffc;
            issue(make_req(addr_list[i], $urandom, 4'hf));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            issue(make_req(addr_list[i] ^ {4'h0, 16'($urandom), 12'h0}, 32'h0, 4'h0));
        end
        idle();

        // byte-strobed merges.
        for (int i = 0; i < 2 * N_WORDS; i++) begin
            strb = 4'($urandom_range(1, 14));
            issue(make_req(addr_list[$urandom_range(0, N_WORDS - 1)], $urandom, strb));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            issue(make_req(addr_list[i], 32'h0, 4'h0));
        end
        idle();

        // console bytes, one with lane 0 masked off.
        for (int i = 0; i < 6; i++) begin
            console_write(8'($urandom), 4'($urandom_range(1, 15)));
            idle();
        end
        console_write(8'h5a, 4'b1110);
        idle();
        wait_drain();

        // burst that overruns the fifo.
        for (int i = 0; i < 2 * `EMU_CONSOLE_DEPTH; i++) begin
            console_write(8'($urandom), 4'h1);
        end
        idle();
        wait_drain();

        // unmapped space over live ram offsets, and console reads.
        for (int i = 0; i < 8; i++) begin
            strb = (i % 2 == 0) ? 4'h0 : 4'($urandom_range(1, 15));
            issue(make_req({4'($urandom_range(2, 15)), addr_list[i][27:0]}, $urandom, strb));
        end
        issue(make_req(`EMU_CONSOLE_ADDR + 32'h4, $urandom, 4'hf));
        issue(make_req(`EMU_CONSOLE_ADDR, 32'h0, 4'h0));
        for (int i = 0; i < N_WORDS; i++) begin
            issue(make_req(addr_list[i], 32'h0, 4'h0));
        end
        idle();
        wait_drain();

        repeat (8 * `EMU_CONSOLE_GAP) @(negedge clk);   // catch stray chars.
        finish_run();
    end

endmodule

/* verilog/axi_ram.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module axi_ram (
    input  logic            clk,
    input  logic            resetn,
    input  logic            awvalid,
    output logic            awready,
    input  logic [31:0]     awaddr,
    input  logic            wvalid,
    output logic            wready,
    input  emu_pkg::axi_w_t w,
    output logic            bvalid,
    input  logic            bready,
    input  logic            arvalid,
    output logic            arready,
    input  logic [31:0]     araddr,
    output logic            rvalid,
    input  logic            rready,
    output logic [31:0]     rdata
);
    import emu_pkg::*;

    localparam int IDX_W = $clog2(`EMU_RAM_WORDS);

    logic [31:0]      mem [`EMU_RAM_WORDS];
    logic             aw_held;
    logic             w_held;
    logic [IDX_W-1:0] aw_idx_q;
    axi_w_t           w_q;
    logic             aw_fire, w_fire, ar_fire;
    logic             do_write;
    logic [IDX_W-1:0] wr_idx;
    axi_w_t           wr_data;

    assign awready = !bvalid && !aw_held;
    assign wready  = !bvalid && !w_held;
    assign arready = !rvalid;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;

    ////////////////////////////////////////
    // write path
    ////////////////////////////////////////

    // either channel may arrive first, the other joins it later.
    assign do_write = (aw_held || aw_fire) && (w_held || w_fire);
    assign wr_idx   = aw_held ? aw_idx_q : awaddr[IDX_W+1:2];
    assign wr_data  = w_held ? w_q : w;

    always_ff @(posedge clk) begin
        if (aw_fire) aw_idx_q <= awaddr[IDX_W+1:2];
        if (w_fire) w_q <= w;
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_data.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_data.data[8*i +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // read path
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ar_fire) rdata <= mem[araddr[IDX_W+1:2]];  // wraps mod ram size.
    end

    ////////////////////////////////////////
    // handshake state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (do_write) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end else begin
                if (aw_fire) aw_held <= 1'b1;
                if (w_fire) w_held <= 1'b1;
            end
            if (do_write) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (ar_fire) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

endmodule

/* verilog/console_drain.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module console_drain (
    input  logic       clk,
    input  logic       resetn,
    input  logic       console_empty,
    input  logic [7:0] console_head,
    output logic       console_pop,
    output logic       char_valid,
    output logic [7:0] char_data
);
    localparam int GAP   = `EMU_CONSOLE_GAP;
    localparam int GAP_W = $clog2(GAP + 1);

    logic [GAP_W-1:0] gap_cnt;

    ////////////////////////////////////////
    // pacing
    ////////////////////////////////////////

    assign console_pop = !console_empty && gap_cnt == '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            gap_cnt    <= '0;
            char_valid <= 1'b0;
        end else begin
            char_valid <= console_pop;
            if (console_pop) gap_cnt <= GAP_W'(GAP);
            else if (gap_cnt != '0) gap_cnt <= gap_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (console_pop) char_data <= console_head;   // shown with char_valid.
    end

endmodule

/* verilog/console_fifo.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module console_fifo (
    input  logic       clk,
    input  logic       resetn,
    input  logic       console_push,
    input  logic [7:0] console_byte,
    input  logic       console_pop,
    output logic [7:0] console_head,
    output logic       console_empty,
    output logic       console_full
);
    localparam int DEPTH = `EMU_CONSOLE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       data_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign console_empty = count == '0;
    assign console_full  = count == CNT_W'(DEPTH);
    assign console_head  = data_q[rd_ptr];

    assign do_push = console_push && !console_full;   // overflow dropped.
    assign do_pop  = console_pop && !console_empty;

    always_ff @(posedge clk) begin
        if (do_push) data_q[wr_ptr] <= console_byte;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/emu_params.svh */
`ifndef EMU_PARAMS_SVH
`define EMU_PARAMS_SVH

////////////////////////////////////////
// memory map
////////////////////////////////////////

`define EMU_RAM_WORDS       1024            // 4 KiB, aliases above.
`define EMU_CONSOLE_ADDR    32'h1000_0000   // byte lane 0 only.

////////////////////////////////////////
// console
////////////////////////////////////////

`define EMU_CONSOLE_DEPTH   8
`define EMU_CONSOLE_GAP     4               // cycles between char strobes.

`endif

/* verilog/emu_pkg.sv */
package emu_pkg;

    ////////////////////////////////////////
    // native memory port
    ////////////////////////////////////////

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;     // zero means read.
        logic        instr;     // fetch hint from the core.
    } mem_req_t;

    ////////////////////////////////////////
    // axi-lite write data channel
    ////////////////////////////////////////

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

endpackage

/* verilog/emu_uncore.sv */
`timescale 1ns/1ps

module emu_uncore (
    input  logic              clk,
    input  logic              resetn,
    input  logic              mem_valid,
    input  emu_pkg::mem_req_t mem_req,
    output logic              mem_ready,
    output logic [31:0]       mem_rdata,
    output logic              char_valid,
    output logic [7:0]        char_data
);
    import emu_pkg::*;

    ////////////////////////////////////////
    // axi-lite between bridge and ram
    ////////////////////////////////////////

    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    axi_w_t      w;
    logic        bvalid;
    logic        bready;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;

    ////////////////////////////////////////
    // console path
    ////////////////////////////////////////

    logic        console_push;
    logic [7:0]  console_byte;
    logic        console_full;
    logic        console_pop;
    logic [7:0]  console_head;
    logic        console_empty;

    mem_axi_bridge bridge0 (
        .clk          (clk),
        .resetn       (resetn),
        .mem_valid    (mem_valid),
        .mem_req      (mem_req),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .w            (w),
        .bvalid       (bvalid),
        .bready       (bready),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .console_push (console_push),
        .console_byte (console_byte),
        .console_full (console_full)
    );

    axi_ram ram0 (
        .clk     (clk),
        .resetn  (resetn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata)
    );

    console_fifo fifo0 (
        .clk           (clk),
        .resetn        (resetn),
        .console_push  (console_push),
        .console_byte  (console_byte),
        .console_pop   (console_pop),
        .console_head  (console_head),
        .console_empty (console_empty),
        .console_full  (console_full)
    );

    console_drain drain0 (
        .clk           (clk),
        .resetn        (resetn),
        .console_empty (console_empty),
        .console_head  (console_head),
        .console_pop   (console_pop),
        .char_valid    (char_valid),
        .char_data     (char_data)
    );

endmodule

/* verilog/mem_axi_bridge.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module mem_axi_bridge (
    input  logic              clk,
    input  logic              resetn,
    input  logic              mem_valid,
    input  emu_pkg::mem_req_t mem_req,
    output logic              mem_ready,
    output logic [31:0]       mem_rdata,
    output logic              awvalid,
    input  logic              awready,
    output logic [31:0]       awaddr,
    output logic              wvalid,
    input  logic              wready,
    output emu_pkg::axi_w_t   w,
    input  logic              bvalid,
    output logic              bready,
    output logic              arvalid,
    input  logic              arready,
    output logic [31:0]       araddr,
    input  logic              rvalid,
    output logic              rready,
    input  logic [31:0]       rdata,
    output logic              console_push,
    output logic [7:0]        console_byte,
    input  logic              console_full
);
    import emu_pkg::*;

    logic is_ram;
    logic is_write;
    logic is_con_wr;
    logic is_other;
    logic aw_fire, w_fire, b_fire, ar_fire, r_fire;
    logic aw_done, w_done, ar_done;
    logic ack_q;            // console or unmapped completion.

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    assign is_ram    = mem_req.addr[31:28] == 4'h0;
    assign is_write  = |mem_req.wstrb;
    assign is_con_wr = is_write && mem_req.addr == `EMU_CONSOLE_ADDR;
    assign is_other  = !is_ram && !is_con_wr;  // includes console reads.

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    ////////////////////////////////////////
    // axi-lite request side
    ////////////////////////////////////////

    assign awvalid = mem_valid && is_ram && is_write && !aw_done;
    assign awaddr  = mem_req.addr;
    assign wvalid  = mem_valid && is_ram && is_write && !w_done;
    assign w       = axi_w_t'{data: mem_req.wdata, strb: mem_req.wstrb};
    assign bready  = aw_done && w_done;
    assign arvalid = mem_valid && is_ram && !is_write && !ar_done;
    assign araddr  = mem_req.addr;
    assign rready  = ar_done;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
        end else begin
            if (b_fire) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                if (aw_fire) aw_done <= 1'b1;
                if (w_fire) w_done <= 1'b1;
            end
            if (r_fire) ar_done <= 1'b0;
            else if (ar_fire) ar_done <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // console and unmapped
    ////////////////////////////////////////

    // hold off while the ack of this request is still out.
    assign console_push = mem_valid && is_con_wr && !console_full && !ack_q;
    assign console_byte = mem_req.wdata[7:0] & {8{mem_req.wstrb[0]}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= console_push || (mem_valid && is_other && !ack_q);
        end
    end

    assign mem_ready = b_fire || r_fire || ack_q;
    assign mem_rdata = r_fire ? rdata : 32'h0;

endmodule
